//--- dram_scrub_pkg.sv
/*
 * Shared definitions for the DRAM scrubbing path
 *   - address, burst length and counter widths
 *   - DDR write-address request struct
 *   - scrubber FSM state encoding
 *   - control word field positions and ID constants
 */

package dram_scrub_pkg;

   // -------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------
   localparam int unsigned ADDR_W     = 64;
   localparam int unsigned LEN_W      = 8;
   localparam int unsigned CNT_W      = 16;

   // One data beat on the DDR port is 512 bits
   localparam int unsigned BEAT_BYTES = 64;

   // -------------------------------------------------------------------
   // DDR write-address request
   // -------------------------------------------------------------------
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } ddr_req_t;

   // Scrubber FSM
   typedef enum logic [1:0] {
      SCRUB_IDLE = 2'd0,
      SCRUB_RUN  = 2'd1,
      SCRUB_DONE = 2'd2
   } scrub_state_e;

   // -------------------------------------------------------------------
   // Control word layout
   // -------------------------------------------------------------------
   // Bit 31 turns the ID outputs into a scrub address readback
   localparam int unsigned CTL_DBG_EN_BIT  = 31;

   // Bits 30:28 pick the channel shown on the ID outputs
   localparam int unsigned CTL_DBG_SEL_LSB = 28;
   localparam int unsigned CTL_DBG_SEL_W   = 3;

   // Identification words when debug readback is off
   localparam logic [31:0] ID0_VALUE = 32'hc0de_5c3b;
   localparam logic [31:0] ID1_VALUE = 32'h0002_0001;

endpackage

//--- ddr_scrubber.sv
/*
 * DRAM scrubber for one channel
 *   Walks the address space from zero in fixed-length bursts and
 *   issues one write-address request per burst. Reports the current
 *   address and a done level once the last burst has been accepted.
 */

`timescale 1ns/1ps

module ddr_scrubber #(
   parameter logic [dram_scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR = 64'h1fff,
   parameter int unsigned SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                                clk,
   input  logic                                sync_rst_n,

   input  logic                                scrub_en,

   // Request port towards the register slice
   input  logic                                req_ready,
   output dram_scrub_pkg::ddr_req_t            req,
   output logic                                req_valid,

   // Status
   output logic [dram_scrub_pkg::ADDR_W-1:0]   scrub_addr,
   output logic                                done
);

   // Bytes covered by one burst
   localparam logic [dram_scrub_pkg::ADDR_W-1:0] SPAN =
      dram_scrub_pkg::ADDR_W'((SCRB_BURST_LEN_MINUS1 + 1) * dram_scrub_pkg::BEAT_BYTES);

   dram_scrub_pkg::scrub_state_e       state;
   logic [dram_scrub_pkg::ADDR_W-1:0]  addr_q;
   logic [dram_scrub_pkg::ADDR_W-1:0]  next_addr;
   logic                               last_burst;
   logic                               req_xfer;

   assign next_addr  = addr_q + SPAN;

   // This burst reaches past the end of the scrub region
   assign last_burst = (next_addr > SCRB_MAX_ADDR);

   assign req_xfer   = req_valid && req_ready;

   // -------------------------------------------------------------------
   // FSM and address walk
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         state  <= dram_scrub_pkg::SCRUB_IDLE;
         addr_q <= '0;
      end
      else if (!scrub_en)
      begin
         // Dropping the enable aborts and rewinds from any state
         state  <= dram_scrub_pkg::SCRUB_IDLE;
         addr_q <= '0;
      end
      else
      begin
         case (state)
            dram_scrub_pkg::SCRUB_IDLE:
            begin
               state <= dram_scrub_pkg::SCRUB_RUN;
            end
            dram_scrub_pkg::SCRUB_RUN:
            begin
               if (req_xfer)
               begin
                  // Address stays on the final burst once done
                  if (last_burst)
                     state <= dram_scrub_pkg::SCRUB_DONE;
                  else
                     addr_q <= next_addr;
               end
            end
            dram_scrub_pkg::SCRUB_DONE:
            begin
               state <= dram_scrub_pkg::SCRUB_DONE;
            end
            default:
            begin
               state <= dram_scrub_pkg::SCRUB_IDLE;
            end
         endcase
      end

   // -------------------------------------------------------------------
   // Outputs
   // -------------------------------------------------------------------
   assign req_valid  = (state == dram_scrub_pkg::SCRUB_RUN);
   assign req.addr   = addr_q;
   assign req.len    = dram_scrub_pkg::LEN_W'(SCRB_BURST_LEN_MINUS1);

   assign scrub_addr = addr_q;
   assign done       = (state == dram_scrub_pkg::SCRUB_DONE);

endmodule

//--- req_slice.sv
/*
 * Two-entry register slice for DDR write-address requests
 *   Registered output, one cycle through, full rate when the
 *   output side is ready. Input ready depends only on fill level.
 */

`timescale 1ns/1ps

module req_slice
(
   input  logic                       clk,
   input  logic                       sync_rst_n,

   input  dram_scrub_pkg::ddr_req_t   in_req,
   input  logic                       in_valid,
   output logic                       in_ready,

   output dram_scrub_pkg::ddr_req_t   out_req,
   output logic                       out_valid,
   input  logic                       out_ready
);

   dram_scrub_pkg::ddr_req_t  entry_q [2];
   logic                      wr_ptr;
   logic                      rd_ptr;
   logic [1:0]                fill;
   logic                      push;
   logic                      pop;

   assign in_ready  = (fill != 2'd2);
   assign out_valid = (fill != 2'd0);
   assign out_req   = entry_q[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // Storage
   always_ff @(posedge clk)
      if (push)
         entry_q[wr_ptr] <= in_req;

   // Pointers and fill level
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         fill   <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= !wr_ptr;
         if (pop)
            rd_ptr <= !rd_ptr;

         // Simultaneous push and pop leaves the level unchanged
         case ({push, pop})
            2'b10:   fill <= fill + 2'd1;
            2'b01:   fill <= fill - 2'd1;
            default: fill <= fill;
         endcase
      end

endmodule

//--- scrub_ctl.sv
/*
 * Scrub control and status
 *   - control word register and per-channel enable decode
 *   - debug readback of a selected scrub address on the ID outputs
 *   - FLR done response
 */

`timescale 1ns/1ps

module scrub_ctl #(
   parameter int unsigned NUM_CHAN = 2,
   parameter int unsigned ADDR_W   = dram_scrub_pkg::ADDR_W
)
(
   input  logic                               clk,
   input  logic                               sync_rst_n,

   input  logic [31:0]                        ctl0,
   input  logic                               flr_assert,
   input  logic [NUM_CHAN-1:0][ADDR_W-1:0]    scrub_addr,

   output logic [NUM_CHAN-1:0]                scrub_en,
   output logic                               flr_done,
   output logic [31:0]                        id0,
   output logic [31:0]                        id1
);

   logic [31:0]                               ctl_q;
   logic                                      dbg_en;
   logic [dram_scrub_pkg::CTL_DBG_SEL_W-1:0]  dbg_sel;
   logic [ADDR_W-1:0]                         sel_addr;
   logic                                      flr_q;

   // -------------------------------------------------------------------
   // Control word
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         ctl_q <= 32'd0;
      else
         ctl_q <= ctl0;

   // Low bits enable one channel each
   assign scrub_en = ctl_q[NUM_CHAN-1:0];

   assign dbg_en  = ctl_q[dram_scrub_pkg::CTL_DBG_EN_BIT];
   assign dbg_sel = ctl_q[dram_scrub_pkg::CTL_DBG_SEL_LSB +: dram_scrub_pkg::CTL_DBG_SEL_W];

   // -------------------------------------------------------------------
   // Debug readback
   // -------------------------------------------------------------------
   // Out of range selects fall back to channel 0
   always_comb
   begin
      sel_addr = scrub_addr[0];
      for (int i = 1; i < NUM_CHAN; i++)
      begin
         if (dbg_sel == i)
            sel_addr = scrub_addr[i];
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         id0 <= dram_scrub_pkg::ID0_VALUE;
         id1 <= dram_scrub_pkg::ID1_VALUE;
      end
      else if (dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= dram_scrub_pkg::ID0_VALUE;
         id1 <= dram_scrub_pkg::ID1_VALUE;
      end

   // -------------------------------------------------------------------
   // FLR response
   // -------------------------------------------------------------------
   // A held request toggles done every cycle
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end

endmodule

//--- ddr_traffic_cnt.sv
/*
 * Request counter for one DDR port
 *   Counts accepted write-address transfers, wraps at full width
 */

`timescale 1ns/1ps

module ddr_traffic_cnt
(
   input  logic                               clk,
   input  logic                               sync_rst_n,

   // Handshake observed on the DDR port
   input  logic                               valid,
   input  logic                               ready,

   output logic [dram_scrub_pkg::CNT_W-1:0]   count
);

   logic xfer;

   assign xfer = valid && ready;

   // Plain binary counter that wraps at CNT_W bits
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         count <= '0;
      else if (xfer)
         count <= count + 1'b1;

endmodule

//--- dram_scrub_top.sv
/*
 * DRAM scrub top level
 *   - control block shared by all channels
 *   - per channel: scrubber, request slice and traffic counter
 *   - status word packing
 */

`timescale 1ns/1ps

module dram_scrub_top #(
   parameter int unsigned NUM_CHAN = 2,
   parameter logic [dram_scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR = 64'h1fff,
   parameter int unsigned SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                                      clk,
   input  logic                                      sync_rst_n,

   input  logic [31:0]                               ctl0,
   input  logic                                      flr_assert,
   input  logic [NUM_CHAN-1:0]                       ddr_ready,

   output dram_scrub_pkg::ddr_req_t [NUM_CHAN-1:0]   ddr_req,
   output logic [NUM_CHAN-1:0]                       ddr_valid,
   output logic                                      flr_done,
   output logic [31:0]                               id0,
   output logic [31:0]                               id1,
   output logic [31:0]                               status0,
   output logic [31:0]                               status1
);

   logic [NUM_CHAN-1:0]                                scrub_en;
   logic [NUM_CHAN-1:0][dram_scrub_pkg::ADDR_W-1:0]    chan_addr;
   logic [NUM_CHAN-1:0]                                chan_done;
   logic [NUM_CHAN-1:0][dram_scrub_pkg::CNT_W-1:0]     chan_cnt;

   scrub_ctl #(
      .NUM_CHAN   (NUM_CHAN),
      .ADDR_W     (dram_scrub_pkg::ADDR_W)
   ) i_scrub_ctl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .scrub_addr (chan_addr),
      .scrub_en   (scrub_en),
      .flr_done   (flr_done),
      .id0        (id0),
      .id1        (id1)
   );

   // -------------------------------------------------------------------
   // Channels
   // -------------------------------------------------------------------
   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chan
      dram_scrub_pkg::ddr_req_t  scrb_req;
      logic                      scrb_valid;
      logic                      scrb_ready;

      ddr_scrubber #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      ) i_scrubber (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .scrub_en   (scrub_en[c]),
         .req_ready  (scrb_ready),
         .req        (scrb_req),
         .req_valid  (scrb_valid),
         .scrub_addr (chan_addr[c]),
         .done       (chan_done[c])
      );

      req_slice i_slice (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_req     (scrb_req),
         .in_valid   (scrb_valid),
         .in_ready   (scrb_ready),
         .out_req    (ddr_req[c]),
         .out_valid  (ddr_valid[c]),
         .out_ready  (ddr_ready[c])
      );

      ddr_traffic_cnt i_traffic_cnt (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .valid      (ddr_valid[c]),
         .ready      (ddr_ready[c]),
         .count      (chan_cnt[c])
      );
   end

   // -------------------------------------------------------------------
   // Status words
   // -------------------------------------------------------------------
   // Counts packed from the low half upward, as many as fit
   always_comb
   begin
      status0 = 32'd0;
      for (int i = 0; i < NUM_CHAN && i < 32 / dram_scrub_pkg::CNT_W; i++)
         status0[i*dram_scrub_pkg::CNT_W +: dram_scrub_pkg::CNT_W] = chan_cnt[i];
   end

   assign status1 = 32'(chan_done);

endmodule

//--- tb_checker.sv
/*
 * Testbench checker
 *   - reference address and request count of one scan
 *   - DDR request monitor, value checks and per-test report
 *   - run timeout
 */

`timescale 1ns/1ps

module tb_checker #(
   parameter int unsigned NUM_CHAN = 2,
   parameter logic [63:0] SCRB_MAX_ADDR = 64'h1fff,
   parameter int unsigned SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                                      clk,
   input  logic                                      sync_rst_n,
   input  logic [31:0]                               ctl0,
   input  logic [NUM_CHAN-1:0]                       ddr_ready,
   input  dram_scrub_pkg::ddr_req_t [NUM_CHAN-1:0]   ddr_req,
   input  logic [NUM_CHAN-1:0]                       ddr_valid,
   input  logic [31:0]                               id0,
   input  logic [31:0]                               id1,
   input  logic [31:0]                               status1,
   input  logic [31:0]                               status0,
   output logic                                      timed_out
);

   // Each channel scans once, then channel 0 restarts
   localparam int NUM_SCANS = 3;

   int next_idx   [NUM_CHAN];
   int xfer_total [NUM_CHAN];
   int test_errors  = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int cycles       = 0;

   function automatic logic [63:0] ref_addr(input int n);
      ref_addr = 64'(n) * 64'((SCRB_BURST_LEN_MINUS1 + 1) * dram_scrub_pkg::BEAT_BYTES);
   endfunction

   // The request whose span passes the last address is the final one
   function automatic int ref_req_count();
      ref_req_count = int'(SCRB_MAX_ADDR / ref_addr(1)) + 1;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_scan(input int c);
      check_value($sformatf("ch%0d done level", c), 1, status1[c]);
      check_value("status1 unused bits", 0, status1 >> NUM_CHAN);
      check_value($sformatf("ch%0d valid after done", c), 0, ddr_valid[c]);
      check_value($sformatf("ch%0d request count", c), ref_req_count(), next_idx[c]);
   endtask

   task automatic check_traffic(input int c);
      check_value($sformatf("ch%0d traffic count", c), xfer_total[c] % 65536,
                  status0[c*dram_scrub_pkg::CNT_W +: dram_scrub_pkg::CNT_W]);
   endtask

   task automatic check_ids(input string name, input logic [63:0] expected);
      check_value(name, expected, {id1, id0});
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("test %s passed", name);
      else
      begin
         $display("test %s failed with %0d errors", name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   // -------------------------------------------------------------------
   // Request monitor
   // -------------------------------------------------------------------
   always @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            next_idx[c]   = 0;
            xfer_total[c] = 0;
         end
      end
      else
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            // Next scan starts from zero once disabled and drained
            if (!ctl0[c] && !ddr_valid[c])
               next_idx[c] = 0;
            if (ddr_valid[c] && ddr_ready[c])
            begin
               if (next_idx[c] >= ref_req_count())
               begin
                  $display("Channel %0d issued a request past the end of the scrub region", c);
                  test_errors++;
               end
               check_value($sformatf("ch%0d request %0d address", c, next_idx[c]),
                           ref_addr(next_idx[c]), ddr_req[c].addr);
               check_value($sformatf("ch%0d request %0d length", c, next_idx[c]),
                           SCRB_BURST_LEN_MINUS1, ddr_req[c].len);
               next_idx[c]++;
               xfer_total[c]++;
            end
         end
      end

   // -------------------------------------------------------------------
   // Timeout
   // -------------------------------------------------------------------
   initial
      timed_out = 1'b0;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles == 4 * NUM_SCANS * ref_req_count() * 10 + 200)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", cycles);
         timed_out <= 1'b1;
      end
   end

endmodule

//--- tb_dram_scrub.sv
/*
 * Testbench top for the DRAM scrub path
 *   - clock, reset and random DDR back-pressure
 *   - test sequence driven on the falling edge
 */

`timescale 1ns/1ps

module tb_dram_scrub;

   localparam int unsigned NUM_CHAN = 2;
   localparam logic [63:0] SCRB_MAX_ADDR = 64'h1fff;
   localparam int unsigned SCRB_BURST_LEN_MINUS1 = 15;
   localparam logic [31:0] DBG_EN = 32'h8000_0000;

   logic                                      clk;
   logic                                      sync_rst_n;
   logic [31:0]                               ctl0;
   logic                                      flr_assert;
   logic [NUM_CHAN-1:0]                       ddr_ready;
   dram_scrub_pkg::ddr_req_t [NUM_CHAN-1:0]   ddr_req;
   logic [NUM_CHAN-1:0]                       ddr_valid;
   logic                                      flr_done;
   logic [31:0]                               id0;
   logic [31:0]                               id1;
   logic [31:0]                               status0;
   logic [31:0]                               status1;
   logic                                      timed_out;
   integer                                    seed = 32'h7e9d_66a2;
   int                                        flr_highs;
   logic                                      flr_expect;

   dram_scrub_top #(
      .NUM_CHAN              (NUM_CHAN),
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   ) i_dut (.*);

   tb_checker #(
      .NUM_CHAN              (NUM_CHAN),
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   ) i_checker (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random back-pressure on every DDR port
   always @(negedge clk)
      ddr_ready = NUM_CHAN'($random(seed));

   initial
   begin
      wait (timed_out === 1'b1);
      $display("STATUS: FAIL");
      $finish;
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Done level seen and the slice drained
   task automatic wait_scan_done(input int c);
      @(negedge clk);
      while (!(status1[c] && !ddr_valid[c]))
         @(negedge clk);
   endtask

   // -------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------
   initial
   begin
      sync_rst_n = 1'b0;
      ctl0       = 32'd0;
      flr_assert = 1'b0;
      ddr_ready  = '0;
      wait_cycles(3);
      sync_rst_n = 1'b1;

      i_checker.check_value("reset ddr_valid", 0, ddr_valid);
      i_checker.check_value("reset flr_done", 0, flr_done);
      i_checker.check_value("reset status0", 0, status0);
      i_checker.check_ids("reset ids", {dram_scrub_pkg::ID1_VALUE, dram_scrub_pkg::ID0_VALUE});
      i_checker.end_test("reset_state");

      ctl0 = 32'd1;
      wait_scan_done(0);
      wait_cycles(10);
      i_checker.check_scan(0);
      i_checker.end_test("scrub_ch0");

      // Channel 1 is still idle, so its address reads back as zero
      ctl0 = DBG_EN | 32'd1;
      wait_cycles(3);
      i_checker.check_ids("debug select 0",
                          i_checker.ref_addr(i_checker.ref_req_count() - 1));
      ctl0 = DBG_EN | (32'd1 << 28) | 32'd1;
      wait_cycles(3);
      i_checker.check_ids("debug select 1", 64'd0);
      ctl0 = DBG_EN | (32'd3 << 28) | 32'd1;
      wait_cycles(3);
      i_checker.check_ids("debug select 3",
                          i_checker.ref_addr(i_checker.ref_req_count() - 1));
      ctl0 = 32'd1;
      wait_cycles(3);
      i_checker.check_ids("debug off", {dram_scrub_pkg::ID1_VALUE, dram_scrub_pkg::ID0_VALUE});
      i_checker.end_test("debug_readback");

      ctl0 = 32'd3;
      wait_scan_done(1);
      wait_cycles(10);
      i_checker.check_scan(1);
      i_checker.end_test("scrub_ch1");

      i_checker.check_traffic(0);
      i_checker.check_traffic(1);
      i_checker.end_test("traffic_count");

      ctl0 = 32'd2;
      wait_cycles(3);
      i_checker.check_value("restart done cleared", 0, status1[0]);
      ctl0 = 32'd3;
      wait_scan_done(0);
      wait_cycles(10);
      i_checker.check_scan(0);
      i_checker.check_traffic(0);
      i_checker.end_test("restart_ch0");

      flr_assert = 1'b1;
      wait_cycles(1);
      flr_assert = 1'b0;
      flr_highs  = 0;
      repeat (8)
      begin
         @(negedge clk);
         flr_highs += flr_done;
      end
      i_checker.check_value("flr single pulse count", 1, flr_highs);

      // Held request toggles done once it first rises
      flr_assert = 1'b1;
      @(negedge clk);
      while (!flr_done)
         @(negedge clk);
      flr_expect = 1'b1;
      repeat (6)
      begin
         @(negedge clk);
         flr_expect = !flr_expect;
         i_checker.check_value("flr held alternation", flr_expect, flr_done);
      end
      flr_assert = 1'b0;
      i_checker.end_test("flr_response");

      $display("tests run: %0d, failed: %0d", i_checker.tests_run, i_checker.tests_failed);
      if (i_checker.tests_failed == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- verilog.f
dram_scrub_pkg.sv
ddr_scrubber.sv
req_slice.sv
scrub_ctl.sv
ddr_traffic_cnt.sv
dram_scrub_top.sv
tb_checker.sv
tb_dram_scrub.sv

//--- Bender.yml
package:
  name: dram_scrub

sources:
  - dram_scrub_pkg.sv
  - ddr_scrubber.sv
  - req_slice.sv
  - scrub_ctl.sv
  - ddr_traffic_cnt.sv
  - dram_scrub_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_dram_scrub.sv
